/* rename_macros.svh */
`ifndef RENAME_MACROS_SVH
`define RENAME_MACROS_SVH

// architectural registers
`define REG_NUM 32
`define REG_SEL 5

// data word
`define DATA_LEN 32

// rename register file, one tag per entry
`define RRF_NUM 64
`define RRF_SEL 6

`endif

/* rename_pkg.sv */
`include "rename_macros.svh"

package rename_pkg;

  // one dispatch slot
  typedef struct packed {
    logic                dst_en;
    logic [`REG_SEL-1:0] dst;
    logic [`REG_SEL-1:0] rs1;
    logic [`REG_SEL-1:0] rs2;
  } rename_req_t;

  // payload is the tag in its low bits while ready is low
  typedef struct packed {
    logic                 ready;
    logic [`DATA_LEN-1:0] data;
  } src_operand_t;

  typedef struct packed {
    logic                 en;
    logic [`RRF_SEL-1:0]  tag;
    logic [`DATA_LEN-1:0] data;
  } wb_t;

  typedef struct packed {
    logic                 we;
    logic [`REG_SEL-1:0]  dst;
    logic [`RRF_SEL-1:0]  tag;
    logic [`DATA_LEN-1:0] data;
  } commit_t;

  typedef enum logic [1:0] {
    src_arf  = 2'd0,
    src_rrf  = 2'd1,
    src_wait = 2'd2
  } src_sel_e;

endpackage

/* arf_data.sv */
`timescale 1ns/1ps
`include "rename_macros.svh"

module arf_data (
  input  logic                 clk_i,
  input  logic                 reset_i,

  input  logic [`REG_SEL-1:0]  raddr1_i,
  input  logic [`REG_SEL-1:0]  raddr2_i,
  output logic [`DATA_LEN-1:0] rdata1_o,
  output logic [`DATA_LEN-1:0] rdata2_o,

  input  logic                 we_i,
  input  logic [`REG_SEL-1:0]  waddr_i,
  input  logic [`DATA_LEN-1:0] wdata_i
);

  logic [`DATA_LEN-1:0] regs_q [`REG_NUM];

  // reads see the value before this cycle's write
  assign rdata1_o = regs_q[raddr1_i];
  assign rdata2_o = regs_q[raddr2_i];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < `REG_NUM; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

endmodule

/* rename_table.sv */
`timescale 1ns/1ps
`include "rename_macros.svh"

module rename_table
  import rename_pkg::*;
(
  input  logic                clk_i,
  input  logic                reset_i,

  // source lookup
  input  logic [`REG_SEL-1:0] rs1_i,
  input  logic [`REG_SEL-1:0] rs2_i,
  output logic                rs1_busy_o,
  output logic                rs2_busy_o,
  output logic [`RRF_SEL-1:0] rs1_tag_o,
  output logic [`RRF_SEL-1:0] rs2_tag_o,

  // retirement clears busy
  input  commit_t             commit_i,

  // dispatch sets busy and tag
  input  logic                set_en_i,
  input  logic [`REG_SEL-1:0] set_num_i,
  input  logic [`RRF_SEL-1:0] set_tag_i
);

  logic [`REG_NUM-1:0] busy_q;
  logic [`RRF_SEL-1:0] tag_q [`REG_NUM];
  logic                clear_hit;

  assign rs1_busy_o = busy_q[rs1_i];
  assign rs2_busy_o = busy_q[rs2_i];
  assign rs1_tag_o  = tag_q[rs1_i];
  assign rs2_tag_o  = tag_q[rs2_i];

  // only the newest rename of a register may free it
  assign clear_hit = commit_i.we && (tag_q[commit_i.dst] == commit_i.tag);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_q <= '0;
    end else begin
      if (clear_hit) begin
        busy_q[commit_i.dst] <= 1'b0;
      end
      // set comes last so a same-cycle rename wins over the clear
      if (set_en_i) begin
        busy_q[set_num_i] <= 1'b1;
        tag_q[set_num_i]  <= set_tag_i;
      end
    end
  end

endmodule

/* arf.sv */
`timescale 1ns/1ps
`include "rename_macros.svh"

module arf
  import rename_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 reset_i,

  input  logic [`REG_SEL-1:0]  rs1_i,
  input  logic [`REG_SEL-1:0]  rs2_i,
  output logic [`DATA_LEN-1:0] rs1_data_o,
  output logic [`DATA_LEN-1:0] rs2_data_o,
  output logic                 rs1_busy_o,
  output logic                 rs2_busy_o,
  output logic [`RRF_SEL-1:0]  rs1_tag_o,
  output logic [`RRF_SEL-1:0]  rs2_tag_o,

  input  commit_t              commit_i,

  input  logic                 set_en_i,
  input  logic [`REG_SEL-1:0]  set_num_i,
  input  logic [`RRF_SEL-1:0]  set_tag_i
);

  // committed values
  arf_data u_arf_data (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .raddr1_i (rs1_i),
    .raddr2_i (rs2_i),
    .rdata1_o (rs1_data_o),
    .rdata2_o (rs2_data_o),
    .we_i     (commit_i.we),
    .waddr_i  (commit_i.dst),
    .wdata_i  (commit_i.data)
  );

  rename_table u_rename_table (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .rs1_i      (rs1_i),
    .rs2_i      (rs2_i),
    .rs1_busy_o (rs1_busy_o),
    .rs2_busy_o (rs2_busy_o),
    .rs1_tag_o  (rs1_tag_o),
    .rs2_tag_o  (rs2_tag_o),
    .commit_i   (commit_i),
    .set_en_i   (set_en_i),
    .set_num_i  (set_num_i),
    .set_tag_i  (set_tag_i)
  );

endmodule

/* rrf.sv */
`timescale 1ns/1ps
`include "rename_macros.svh"

module rrf
  import rename_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 reset_i,

  // result from the execution side
  input  wb_t                  wb_i,

  // new tag handed out at dispatch
  input  logic                 alloc_en_i,
  input  logic [`RRF_SEL-1:0]  alloc_tag_i,

  // source reads
  input  logic [`RRF_SEL-1:0]  rtag1_i,
  input  logic [`RRF_SEL-1:0]  rtag2_i,
  output logic [`DATA_LEN-1:0] rdata1_o,
  output logic [`DATA_LEN-1:0] rdata2_o,
  output logic                 rvalid1_o,
  output logic                 rvalid2_o,

  // oldest entry, for retirement
  input  logic [`RRF_SEL-1:0]  head_tag_i,
  output logic [`DATA_LEN-1:0] head_data_o,
  output logic                 head_valid_o
);

  logic [`DATA_LEN-1:0] data_q [`RRF_NUM];
  logic [`RRF_NUM-1:0]  valid_q;

  // no bypass of a same-cycle writeback
  assign rdata1_o     = data_q[rtag1_i];
  assign rdata2_o     = data_q[rtag2_i];
  assign rvalid1_o    = valid_q[rtag1_i];
  assign rvalid2_o    = valid_q[rtag2_i];
  assign head_data_o  = data_q[head_tag_i];
  assign head_valid_o = valid_q[head_tag_i];

  always_ff @(posedge clk_i) begin
    if (wb_i.en) begin
      data_q[wb_i.tag] <= wb_i.data;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= '0;
    end else begin
      if (wb_i.en) begin
        valid_q[wb_i.tag] <= 1'b1;
      end
      // a fresh allocation starts out empty
      if (alloc_en_i) begin
        valid_q[alloc_tag_i] <= 1'b0;
      end
    end
  end

endmodule

/* rrf_alloc.sv */
`timescale 1ns/1ps
`include "rename_macros.svh"

module rrf_alloc
  import rename_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 reset_i,

  // dispatch side
  input  logic                 disp_en_i,
  input  rename_req_t          disp_req_i,
  output logic                 alloc_en_o,
  output logic [`RRF_SEL-1:0]  alloc_tag_o,
  output logic                 full_o,

  // retirement side
  output logic [`RRF_SEL-1:0]  head_tag_o,
  input  logic                 head_valid_i,
  input  logic [`DATA_LEN-1:0] head_data_i,
  output commit_t              commit_o
);

  logic [`RRF_SEL-1:0] head_q;
  logic [`RRF_SEL-1:0] tail_q;
  logic [`RRF_SEL:0]   count_q;
  logic [`REG_SEL-1:0] dst_q [`RRF_NUM];
  logic                empty;
  logic                retire;

  assign full_o = (count_q == (`RRF_SEL+1)'(`RRF_NUM));
  assign empty  = (count_q == '0);

  // next tag is always the tail
  assign alloc_tag_o = tail_q;
  assign alloc_en_o  = disp_en_i && !full_o && disp_req_i.dst_en;

  // oldest entry leaves once its result is in
  assign head_tag_o = head_q;
  assign retire     = !empty && head_valid_i;

  assign commit_o.we   = retire;
  assign commit_o.dst  = dst_q[head_q];
  assign commit_o.tag  = head_q;
  assign commit_o.data = head_data_i;

  always_ff @(posedge clk_i) begin
    if (alloc_en_o) begin
      dst_q[tail_q] <= disp_req_i.dst;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else begin
      if (alloc_en_o) begin
        tail_q <= tail_q + 1'b1;
      end
      if (retire) begin
        head_q <= head_q + 1'b1;
      end
      // pointers wrap on their own, the count tracks occupancy
      if (alloc_en_o && !retire) begin
        count_q <= count_q + 1'b1;
      end else if (!alloc_en_o && retire) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

/* operand_select.sv */
`timescale 1ns/1ps
`include "rename_macros.svh"

module operand_select
  import rename_pkg::*;
(
  input  logic                 busy1_i,
  input  logic                 busy2_i,
  input  logic [`RRF_SEL-1:0]  tag1_i,
  input  logic [`RRF_SEL-1:0]  tag2_i,
  input  logic [`DATA_LEN-1:0] arf1_i,
  input  logic [`DATA_LEN-1:0] arf2_i,
  input  logic [`DATA_LEN-1:0] rrf1_i,
  input  logic [`DATA_LEN-1:0] rrf2_i,
  input  logic                 valid1_i,
  input  logic                 valid2_i,
  output src_operand_t         src1_o,
  output src_operand_t         src2_o
);

  src_sel_e sel1;
  src_sel_e sel2;

  function automatic src_sel_e pick(input logic busy, input logic valid);
    if (!busy) begin
      return src_arf;
    end
    return valid ? src_rrf : src_wait;
  endfunction

  function automatic src_operand_t build(input src_sel_e sel,
                                         input logic [`RRF_SEL-1:0] tag,
                                         input logic [`DATA_LEN-1:0] arf_val,
                                         input logic [`DATA_LEN-1:0] rrf_val);
    src_operand_t op;
    case (sel)
      src_arf: op = '{ready: 1'b1, data: arf_val};
      src_rrf: op = '{ready: 1'b1, data: rrf_val};
      // still in flight, hand out the tag to wait on
      default: op = '{ready: 1'b0, data: `DATA_LEN'(tag)};
    endcase
    return op;
  endfunction

  assign sel1   = pick(busy1_i, valid1_i);
  assign sel2   = pick(busy2_i, valid2_i);
  assign src1_o = build(sel1, tag1_i, arf1_i, rrf1_i);
  assign src2_o = build(sel2, tag2_i, arf2_i, rrf2_i);

endmodule

/* rename_top.sv */
`timescale 1ns/1ps
`include "rename_macros.svh"

module rename_top
  import rename_pkg::*;
(
  input  logic                clk_i,
  input  logic                reset_i,

  input  logic                disp_en_i,
  input  rename_req_t         disp_req_i,
  output logic [`RRF_SEL-1:0] disp_tag_o,
  output logic                full_o,
  output src_operand_t        src1_o,
  output src_operand_t        src2_o,

  input  wb_t                 wb_i,
  output commit_t             commit_o
);

  logic [`DATA_LEN-1:0] arf_data1;
  logic [`DATA_LEN-1:0] arf_data2;
  logic                 busy1;
  logic                 busy2;
  logic [`RRF_SEL-1:0]  tag1;
  logic [`RRF_SEL-1:0]  tag2;
  logic [`DATA_LEN-1:0] rrf_data1;
  logic [`DATA_LEN-1:0] rrf_data2;
  logic                 rrf_valid1;
  logic                 rrf_valid2;
  logic                 alloc_en;
  logic [`RRF_SEL-1:0]  head_tag;
  logic [`DATA_LEN-1:0] head_data;
  logic                 head_valid;

  arf u_arf (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .rs1_i      (disp_req_i.rs1),
    .rs2_i      (disp_req_i.rs2),
    .rs1_data_o (arf_data1),
    .rs2_data_o (arf_data2),
    .rs1_busy_o (busy1),
    .rs2_busy_o (busy2),
    .rs1_tag_o  (tag1),
    .rs2_tag_o  (tag2),
    .commit_i   (commit_o),
    .set_en_i   (alloc_en),
    .set_num_i  (disp_req_i.dst),
    .set_tag_i  (disp_tag_o)
  );

  rrf u_rrf (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .wb_i         (wb_i),
    .alloc_en_i   (alloc_en),
    .alloc_tag_i  (disp_tag_o),
    .rtag1_i      (tag1),
    .rtag2_i      (tag2),
    .rdata1_o     (rrf_data1),
    .rdata2_o     (rrf_data2),
    .rvalid1_o    (rrf_valid1),
    .rvalid2_o    (rrf_valid2),
    .head_tag_i   (head_tag),
    .head_data_o  (head_data),
    .head_valid_o (head_valid)
  );

  rrf_alloc u_rrf_alloc (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .disp_en_i    (disp_en_i),
    .disp_req_i   (disp_req_i),
    .alloc_en_o   (alloc_en),
    .alloc_tag_o  (disp_tag_o),
    .full_o       (full_o),
    .head_tag_o   (head_tag),
    .head_valid_i (head_valid),
    .head_data_i  (head_data),
    .commit_o     (commit_o)
  );

  operand_select u_operand_select (
    .busy1_i  (busy1),
    .busy2_i  (busy2),
    .tag1_i   (tag1),
    .tag2_i   (tag2),
    .arf1_i   (arf_data1),
    .arf2_i   (arf_data2),
    .rrf1_i   (rrf_data1),
    .rrf2_i   (rrf_data2),
    .valid1_i (rrf_valid1),
    .valid2_i (rrf_valid2),
    .src1_o   (src1_o),
    .src2_o   (src2_o)
  );

endmodule

/* tb_rename_top.sv */
`timescale 1ns/1ps
`include "rename_macros.svh"

module tb_rename_top
  import rename_pkg::*;
();

  localparam logic [1:0] wb_none   = 2'd0;
  localparam logic [1:0] wb_oldest = 2'd1;
  localparam logic [1:0] wb_newest = 2'd2;

  // one table row per cycle
  typedef struct packed {
    logic        disp_en;
    rename_req_t req;
    logic [1:0]  wb_mode;
  } row_t;

  logic                clk_i;
  logic                reset_i;
  logic                disp_en_i;
  rename_req_t         disp_req_i;
  wb_t                 wb_i;
  logic [`RRF_SEL-1:0] disp_tag_o;
  logic                full_o;
  src_operand_t        src1_o;
  src_operand_t        src2_o;
  commit_t             commit_o;

  // reference model state
  logic [`DATA_LEN-1:0] m_arf [`REG_NUM];
  logic [`REG_NUM-1:0]  m_busy;
  logic [`RRF_SEL-1:0]  m_tag [`REG_NUM];
  logic [`DATA_LEN-1:0] m_val [`RRF_NUM];
  logic [`RRF_NUM-1:0]  m_valid;
  logic [`REG_SEL-1:0]  m_dst [`RRF_NUM];
  logic [`RRF_SEL-1:0]  m_tail;
  logic [`RRF_SEL-1:0]  commit_q [$];
  logic [`RRF_SEL-1:0]  pending_q [$];

  row_t        rows_q [$];
  row_t        cur_row;
  logic [31:0] lfsr_q = 32'd7;
  int          cycles = 0;
  int          limit = 100000;

  rename_top dut (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .disp_en_i  (disp_en_i),
    .disp_req_i (disp_req_i),
    .disp_tag_o (disp_tag_o),
    .full_o     (full_o),
    .src1_o     (src1_o),
    .src2_o     (src2_o),
    .wb_i       (wb_i),
    .commit_o   (commit_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
    end
    return r;
  endfunction

  task automatic add_row(input logic en, input logic dst_en, input int dst,
                         input int rs1, input int rs2, input logic [1:0] wb);
    row_t r;
    r.disp_en    = en;
    r.req.dst_en = dst_en;
    r.req.dst    = `REG_SEL'(dst);
    r.req.rs1    = `REG_SEL'(rs1);
    r.req.rs2    = `REG_SEL'(rs2);
    r.wb_mode    = wb;
    rows_q.push_back(r);
  endtask

  task automatic build_table();
    for (int i = 0; i < 4; i++) add_row(0, 0, 0, i, 31 - i, wb_none);
    add_row(1, 1, 5, 1, 2, wb_none);
    add_row(1, 1, 6, 5, 5, wb_none);
    add_row(1, 1, 7, 5, 6, wb_none);
    // youngest result first, retirement has to wait
    add_row(0, 0, 0, 7, 5, wb_newest);
    for (int i = 0; i < 2; i++) add_row(0, 0, 0, 7, 6, wb_oldest);
    for (int i = 0; i < 3; i++) add_row(0, 0, 0, 5, 7, wb_none);
    // x9 renamed twice, older tag retires first
    add_row(1, 1, 9, 0, 0, wb_none);
    add_row(1, 1, 9, 9, 0, wb_none);
    add_row(0, 0, 0, 9, 9, wb_oldest);
    for (int i = 0; i < 3; i++) add_row(0, 0, 0, 9, 9, wb_none);
    add_row(0, 0, 0, 9, 9, wb_oldest);
    add_row(1, 0, 3, 9, 5, wb_none);
    // run into full, then free one entry
    for (int i = 0; i < 70; i++) add_row(1, 1, i % 32, (i + 1) % 32, i % 32, wb_none);
    add_row(1, 1, 12, 12, 4, wb_oldest);
    for (int i = 0; i < 3; i++) add_row(1, 1, 13 + i, 12, 13, wb_none);
    for (int i = 0; i < 80; i++) add_row(0, 0, 0, i % 32, (i * 7) % 32, wb_oldest);
    for (int i = 0; i < 160; i++) begin
      add_row(take_bits(1), take_bits(1), int'(take_bits(3)), int'(take_bits(3)),
              int'(take_bits(3)), (take_bits(2) == 2'd3) ? wb_oldest : 2'(take_bits(2)));
    end
    for (int i = 0; i < 80; i++) add_row(0, 0, 0, i % 8, 7 - (i % 8), wb_oldest);
  endtask

  function automatic src_operand_t expect_operand(input logic [`REG_SEL-1:0] r);
    src_sel_e sel;
    if (!m_busy[r]) sel = src_arf;
    else if (m_valid[m_tag[r]]) sel = src_rrf;
    else sel = src_wait;
    if (sel == src_arf) return '{ready: 1'b1, data: m_arf[r]};
    if (sel == src_rrf) return '{ready: 1'b1, data: m_val[m_tag[r]]};
    return '{ready: 1'b0, data: `DATA_LEN'(m_tag[r])};
  endfunction

  task automatic fail_run();
    $display("Test failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic value_error(input string what, input logic [63:0] got, input logic [63:0] exp);
    $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    fail_run();
  endtask

  task automatic drive_row(input row_t r);
    wb_t wb;
    wb = '0;
    cur_row = r;
    if (r.wb_mode != wb_none && pending_q.size() != 0) begin
      wb.en   = 1'b1;
      wb.tag  = (r.wb_mode == wb_oldest) ? pending_q.pop_front() : pending_q.pop_back();
      wb.data = take_bits(32);
    end
    disp_en_i  = r.disp_en;
    disp_req_i = r.req;
    wb_i       = wb;
  endtask

  task automatic check_outputs();
    src_operand_t e1;
    src_operand_t e2;
    commit_t      ec;
    logic         ef;
    e1 = expect_operand(cur_row.req.rs1);
    e2 = expect_operand(cur_row.req.rs2);
    ef = (commit_q.size() == `RRF_NUM);
    ec = '0;
    if (commit_q.size() != 0 && m_valid[commit_q[0]]) begin
      ec = '{we: 1'b1, dst: m_dst[commit_q[0]], tag: commit_q[0], data: m_val[commit_q[0]]};
    end
    assert (src1_o === e1) else value_error("src1_o", 64'(src1_o), 64'(e1));
    assert (src2_o === e2) else value_error("src2_o", 64'(src2_o), 64'(e2));
    assert (full_o === ef) else value_error("full_o", 64'(full_o), 64'(ef));
    assert (disp_tag_o === m_tail) else value_error("disp_tag_o", 64'(disp_tag_o), 64'(m_tail));
    if (ec.we) begin
      assert (commit_o === ec) else value_error("commit_o", 64'(commit_o), 64'(ec));
    end else begin
      assert (commit_o.we === 1'b0) else value_error("commit_o.we", 64'(commit_o.we), 64'd0);
    end
  endtask

  // next state at the coming edge, clear before set
  task automatic step_model();
    logic                alloc;
    logic [`RRF_SEL-1:0] htag;
    logic [`REG_SEL-1:0] hdst;
    alloc = cur_row.disp_en && cur_row.req.dst_en && (commit_q.size() < `RRF_NUM);
    if (commit_q.size() != 0 && m_valid[commit_q[0]]) begin
      htag = commit_q.pop_front();
      hdst = m_dst[htag];
      m_arf[hdst] = m_val[htag];
      if (m_tag[hdst] == htag) m_busy[hdst] = 1'b0;
    end
    if (wb_i.en) begin
      m_val[wb_i.tag]   = wb_i.data;
      m_valid[wb_i.tag] = 1'b1;
    end
    if (alloc) begin
      m_valid[m_tail] = 1'b0;
      m_dst[m_tail] = cur_row.req.dst;
      m_busy[cur_row.req.dst] = 1'b1;
      m_tag[cur_row.req.dst] = m_tail;
      commit_q.push_back(m_tail);
      pending_q.push_back(m_tail);
      m_tail = m_tail + `RRF_SEL'(1);
    end
  endtask

  always @(posedge clk_i) begin
    cycles++;
    if (cycles > limit) begin
      $display("timeout: the run did not end within %0d cycles", limit);
      fail_run();
    end
  end

  initial begin
    reset_i    = 1'b1;
    disp_en_i  = 1'b0;
    disp_req_i = '0;
    wb_i       = '0;
    for (int i = 0; i < `REG_NUM; i++) begin
      m_arf[i] = '0;
      m_tag[i] = '0;
    end
    m_busy  = '0;
    m_valid = '0;
    m_tail  = '0;
    build_table();
    limit = rows_q.size() * 4 + 200;
    repeat (16) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    foreach (rows_q[i]) begin
      drive_row(rows_q[i]);
      #4;
      check_outputs();
      step_model();
      @(posedge clk_i);
      #1;
    end
    disp_en_i = 1'b0;
    wb_i      = '0;
    $display("Test passed");
    $finish;
  end

endmodule

/* all.f */
+incdir+.
rename_pkg.sv
arf_data.sv
rename_table.sv
arf.sv
rrf.sv
rrf_alloc.sv
operand_select.sv
rename_top.sv
tb_rename_top.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_rename_top
FILELIST  = all.f
OBJ_DIR   = obj_dir
PASS_MSG  = Test passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
